/* src/spi_flash_cfg.svh */
// Geometry assumes 4 equal sectors filling the 12-bit array; busy times are in system clock cycles
`ifndef SPI_FLASH_CFG_SVH
`define SPI_FLASH_CFG_SVH

////////////////////////////////////////////////////////////
// Array geometry
////////////////////////////////////////////////////////////
`define FLASH_ADDR_BITS    12
`define FLASH_PAGE_BYTES   32
`define FLASH_SECTOR_BYTES 1024
`define FLASH_SECTORS      4

////////////////////////////////////////////////////////////
// Busy times
////////////////////////////////////////////////////////////
`define FLASH_PROG_CYCLES  64
`define FLASH_ERASE_CYCLES 256

// Status register layout
`define SR_WIP    0
`define SR_WEL    1
`define SR_BP_LSB 2

`endif

/* src/spi_flash_pkg.sv */
// Only the low FLASH_ADDR_BITS of the 24-bit SPI address survive into flash_addr_t
`include "spi_flash_cfg.svh"

package spi_flash_pkg;

    typedef logic [7:0]                  byte_t;
    typedef logic [`FLASH_ADDR_BITS-1:0] flash_addr_t;
    typedef logic [4:0]                  page_off_t;   // Byte inside a 32-byte page
    typedef logic [2:0]                  bp_t;

    // Opcodes kept from the original part
    typedef enum logic [7:0] {
        OPC_WRSR = 8'h01,
        OPC_PP   = 8'h02,
        OPC_READ = 8'h03,
        OPC_WRDI = 8'h04,
        OPC_RDSR = 8'h05,
        OPC_WREN = 8'h06,
        OPC_SE   = 8'hD8
    } opcode_e;

    typedef enum logic [1:0] {PH_OPCODE, PH_ADDR, PH_DATA, PH_IGNORE} spi_phase_e;

    typedef enum logic [2:0] {OP_NONE, OP_READ, OP_BUF_WR, OP_PROGRAM, OP_ERASE} flash_op_e;

    typedef enum logic [1:0] {ARR_IDLE, ARR_PROG, ARR_ERASE} array_state_e;

    typedef struct packed {
        logic  byte_valid;   // One cycle per received byte
        byte_t data;
        logic  frame_end;    // One cycle at deselect
    } spi_rx_t;

    typedef struct packed {
        flash_op_e   op;
        flash_addr_t addr;
        byte_t       data;
    } flash_req_t;

    typedef struct packed {
        logic  busy;
        byte_t rd_data;
    } flash_rsp_t;

endpackage

/* src/spi_frontend.sv */
// SPI mode 0 only; sck half period must span at least 4 system clocks for the 2-stage sync
`timescale 1ns/1ps

module spi_frontend import spi_flash_pkg::*; (
    input  logic    CSNeg_ipd,
    input  logic    arst_n,
    input  logic    sck,
    input  logic    cs_n,
    input  logic    si,
    input  byte_t   tx_byte,
    output spi_rx_t rx,
    output logic    so
);

    logic [2:0] sck_q;
    logic [2:0] cs_q;
    logic [1:0] si_q;
    logic       sck_rise, sck_fall;
    logic       cs_rise, cs_fall;
    logic       active;
    logic [2:0] bit_cnt;
    logic       reload_pend;   // Next sck fall loads a fresh byte
    byte_t      rx_shift;
    byte_t      tx_shift;

    ////////////////////////////////////////////////////////////
    // Synchronizers and edge detect
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CSNeg_ipd or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sck_q <= '0;
            cs_q  <= '1;   // Deselected
            si_q  <= '0;
        end
        else
        begin
            sck_q <= {sck_q[1:0], sck};
            cs_q  <= {cs_q[1:0], cs_n};
            si_q  <= {si_q[0], si};
        end
    end

    assign sck_rise = sck_q[1] & ~sck_q[2];
    assign sck_fall = ~sck_q[1] & sck_q[2];
    assign cs_rise  = cs_q[1] & ~cs_q[2];
    assign cs_fall  = ~cs_q[1] & cs_q[2];
    assign active   = ~cs_q[1];

    // Receive shifter, MSB first
    always_ff @(posedge CSNeg_ipd)
    begin
        if (active && sck_rise)
            rx_shift <= {rx_shift[6:0], si_q[1]};
    end

    ////////////////////////////////////////////////////////////
    // Bit count, byte strobe and transmit shifter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CSNeg_ipd or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bit_cnt     <= '0;
            reload_pend <= 1'b0;
            tx_shift    <= '0;
            rx          <= '0;
        end
        else
        begin
            rx.byte_valid <= 1'b0;
            rx.frame_end  <= cs_rise;
            if (!active)
            begin
                bit_cnt     <= '0;
                reload_pend <= 1'b0;
                tx_shift    <= '0;
            end
            else if (cs_fall)
            begin
                tx_shift <= tx_byte;   // First byte out before the first sck rise
                bit_cnt  <= '0;
            end
            else
            begin
                if (sck_rise)
                begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7)
                    begin
                        rx.byte_valid <= 1'b1;
                        rx.data       <= {rx_shift[6:0], si_q[1]};
                        reload_pend   <= 1'b1;
                    end
                end
                if (sck_fall)
                begin
                    reload_pend <= 1'b0;
                    if (reload_pend)
                        tx_shift <= tx_byte;
                    else
                        tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

    assign so = tx_shift[7] & ~cs_n;   // Output off as soon as the pin deselects

endmodule

/* src/cmd_sequencer.sv */
// Commands other than RDSR are dropped while WIP is set; extra bytes after SE or WREN are ignored
`timescale 1ns/1ps
`include "spi_flash_cfg.svh"

module cmd_sequencer import spi_flash_pkg::*; (
    input  logic       CSNeg_ipd,
    input  logic       arst_n,
    input  spi_rx_t    rx,
    input  flash_rsp_t rsp,
    output flash_req_t req,
    output byte_t      tx_byte
);

    localparam int SEC_W = $clog2(`FLASH_SECTORS);

    spi_phase_e  phase_q;
    opcode_e     op_q;
    logic [1:0]  addr_cnt_q;
    flash_addr_t addr_q;
    flash_addr_t addr_next;
    flash_addr_t rd_addr_q;
    page_off_t   pg_off_q;
    byte_t       wr_data_q;    // First data byte, used by WRSR
    logic        have_data_q;
    logic        wel_q;
    bp_t         bp_q;
    logic        prot;
    byte_t       status;

    // Low address bits only, upper bytes fall off the end
    assign addr_next = flash_addr_t'({addr_q, rx.data});

    // BP level to protected sector count, counted from the top
    always_comb
    begin
        int n_prot;
        n_prot = (bp_q > 3'd2) ? `FLASH_SECTORS : int'(bp_q);
        prot   = (int'(addr_q[`FLASH_ADDR_BITS-1 -: SEC_W]) + n_prot) >= `FLASH_SECTORS;
    end

    always_comb
    begin
        status = '0;
        status[`SR_WIP] = rsp.busy;
        status[`SR_WEL] = wel_q;
        status[`SR_BP_LSB +: $bits(bp_t)] = bp_q;
    end

    always_comb
    begin
        tx_byte = '0;
        if (phase_q == PH_DATA)
        begin
            if (op_q == OPC_RDSR)
                tx_byte = status;        // Repeats until deselect
            else if (op_q == OPC_READ)
                tx_byte = rsp.rd_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Opcode, address and data pointers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CSNeg_ipd)
    begin
        if (rx.byte_valid)
        begin
            case (phase_q)
                PH_OPCODE: op_q <= opcode_e'(rx.data);
                PH_ADDR:
                begin
                    addr_q    <= addr_next;
                    rd_addr_q <= addr_next + 1'b1;
                    pg_off_q  <= page_off_t'(addr_next);
                end
                PH_DATA:
                begin
                    if (!have_data_q)
                        wr_data_q <= rx.data;
                    rd_addr_q <= rd_addr_q + 1'b1;   // Wraps at the top of the array
                    pg_off_q  <= pg_off_q + 1'b1;    // Wraps inside the page
                end
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Phase FSM, status bits and array requests
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CSNeg_ipd or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase_q     <= PH_OPCODE;
            addr_cnt_q  <= '0;
            have_data_q <= 1'b0;
            wel_q       <= 1'b0;
            bp_q        <= '0;
            req         <= '0;
        end
        else
        begin
            req.op <= OP_NONE;
            if (rx.frame_end)
            begin
                if (phase_q == PH_DATA)
                begin
                    case (op_q)
                        OPC_WREN: wel_q <= 1'b1;
                        OPC_WRDI: wel_q <= 1'b0;
                        OPC_WRSR:
                        begin
                            if (wel_q && have_data_q)
                            begin
                                bp_q  <= wr_data_q[`SR_BP_LSB +: $bits(bp_t)];
                                wel_q <= 1'b0;
                            end
                        end
                        OPC_PP:
                        begin
                            if (wel_q && !prot && have_data_q)
                            begin
                                req.op   <= OP_PROGRAM;
                                req.addr <= addr_q;
                                wel_q    <= 1'b0;
                            end
                        end
                        OPC_SE:
                        begin
                            if (wel_q && !prot)
                            begin
                                req.op   <= OP_ERASE;
                                req.addr <= addr_q;
                                wel_q    <= 1'b0;
                            end
                        end
                        default: ;
                    endcase
                end
                phase_q     <= PH_OPCODE;
                addr_cnt_q  <= '0;
                have_data_q <= 1'b0;
            end
            else if (rx.byte_valid)
            begin
                case (phase_q)
                    PH_OPCODE:
                    begin
                        if (rsp.busy && rx.data != OPC_RDSR)
                            phase_q <= PH_IGNORE;
                        else
                        begin
                            case (rx.data)
                                OPC_WREN, OPC_WRDI, OPC_RDSR, OPC_WRSR: phase_q <= PH_DATA;
                                OPC_READ, OPC_PP, OPC_SE:               phase_q <= PH_ADDR;
                                default:                                phase_q <= PH_IGNORE;
                            endcase
                        end
                    end
                    PH_ADDR:
                    begin
                        addr_cnt_q <= addr_cnt_q + 2'd1;
                        if (addr_cnt_q == 2'd2)
                        begin
                            phase_q <= PH_DATA;
                            if (op_q == OPC_READ)
                            begin
                                req.op   <= OP_READ;   // First byte ready before the next load
                                req.addr <= addr_next;
                            end
                        end
                    end
                    PH_DATA:
                    begin
                        have_data_q <= 1'b1;
                        if (op_q == OPC_READ)
                        begin
                            req.op   <= OP_READ;
                            req.addr <= rd_addr_q;
                        end
                        else if (op_q == OPC_PP && wel_q && !prot)
                        begin
                            req.op   <= OP_BUF_WR;
                            req.addr <= {addr_q[`FLASH_ADDR_BITS-1:$bits(page_off_t)], pg_off_q};
                            req.data <= rx.data;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* src/flash_array.sv */
// Reset fills every byte with FFh, which suits simulation only; a program can only clear bits
`timescale 1ns/1ps
`include "spi_flash_cfg.svh"

module flash_array import spi_flash_pkg::*; (
    input  logic       CSNeg_ipd,
    input  logic       arst_n,
    input  flash_req_t req,
    output flash_rsp_t rsp
);

    localparam int MEM_BYTES = `FLASH_SECTORS * `FLASH_SECTOR_BYTES;
    localparam int CNT_W     = $clog2(`FLASH_ERASE_CYCLES + 1);

    byte_t                        mem [MEM_BYTES];
    byte_t                        pbuf [`FLASH_PAGE_BYTES];
    logic [`FLASH_PAGE_BYTES-1:0] pbuf_vld;
    array_state_e                 state_q;
    logic [CNT_W-1:0]             cnt_q;
    flash_addr_t                  op_addr_q;
    flash_addr_t                  page_base;
    flash_addr_t                  sec_base;
    page_off_t                    off;
    logic                         busy;
    logic                         done;
    byte_t                        rd_data_q;

    assign off       = page_off_t'(req.addr);
    assign page_base = op_addr_q & ~flash_addr_t'(`FLASH_PAGE_BYTES - 1);
    assign sec_base  = op_addr_q & ~flash_addr_t'(`FLASH_SECTOR_BYTES - 1);
    assign busy      = (state_q != ARR_IDLE);
    assign done      = busy && (cnt_q == '0);   // Last busy cycle
    assign rsp       = '{busy: busy, rd_data: rd_data_q};

    ////////////////////////////////////////////////////////////
    // Busy FSM and page buffer valid bits
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CSNeg_ipd or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q   <= ARR_IDLE;
            cnt_q     <= '0;
            pbuf_vld  <= '0;
            op_addr_q <= '0;
        end
        else
        begin
            if (req.op == OP_BUF_WR)
                pbuf_vld[off] <= 1'b1;
            case (state_q)
                ARR_IDLE:
                begin
                    if (req.op == OP_PROGRAM)
                    begin
                        state_q   <= ARR_PROG;
                        cnt_q     <= CNT_W'(`FLASH_PROG_CYCLES - 1);
                        op_addr_q <= req.addr;
                    end
                    else if (req.op == OP_ERASE)
                    begin
                        state_q   <= ARR_ERASE;
                        cnt_q     <= CNT_W'(`FLASH_ERASE_CYCLES - 1);
                        op_addr_q <= req.addr;
                    end
                end
                default:
                begin
                    if (cnt_q == '0)
                    begin
                        if (state_q == ARR_PROG)
                            pbuf_vld <= '0;   // Buffer consumed
                        state_q <= ARR_IDLE;
                    end
                    else
                        cnt_q <= cnt_q - 1'b1;
                end
            endcase
        end
    end

    // Storage, committed at the end of the busy time
    always_ff @(posedge CSNeg_ipd or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < MEM_BYTES; i++)
                mem[i] <= 8'hFF;
        end
        else if (done && state_q == ARR_PROG)
        begin
            for (int i = 0; i < `FLASH_PAGE_BYTES; i++)
            begin
                if (pbuf_vld[i])
                    mem[page_base + flash_addr_t'(i)] <= mem[page_base + flash_addr_t'(i)] & pbuf[i];
            end
        end
        else if (done && state_q == ARR_ERASE)
        begin
            for (int i = 0; i < `FLASH_SECTOR_BYTES; i++)
                mem[sec_base + flash_addr_t'(i)] <= 8'hFF;
        end
    end

    always_ff @(posedge CSNeg_ipd)
    begin
        if (req.op == OP_BUF_WR)
            pbuf[off] <= req.data;   // Later bytes overwrite on page wrap
        if (req.op == OP_READ)
            rd_data_q <= mem[req.addr];
    end

endmodule

/* src/spi_flash_top.sv */
// SPI pins are sampled by the system clock; so is driven low, never tristated, while deselected
`timescale 1ns/1ps

module spi_flash_top import spi_flash_pkg::*; (
    input  logic CSNeg_ipd,
    input  logic arst_n,
    input  logic sck,
    input  logic cs_n,
    input  logic si,
    output logic so
);

    spi_rx_t    rx;
    byte_t      tx_byte;
    flash_req_t req;
    flash_rsp_t rsp;

    spi_frontend i_spi_frontend (
        .CSNeg_ipd (CSNeg_ipd),
        .arst_n    (arst_n),
        .sck       (sck),
        .cs_n      (cs_n),
        .si        (si),
        .tx_byte   (tx_byte),
        .rx        (rx),
        .so        (so)
    );

    cmd_sequencer i_cmd_sequencer (
        .CSNeg_ipd (CSNeg_ipd),
        .arst_n    (arst_n),
        .rx        (rx),
        .rsp       (rsp),
        .req       (req),
        .tx_byte   (tx_byte)
    );

    flash_array i_flash_array (
        .CSNeg_ipd (CSNeg_ipd),
        .arst_n    (arst_n),
        .req       (req),
        .rsp       (rsp)
    );

endmodule

/* verification/spi_flash_sva.sv */
// Bound into spi_flash_top; all checks are held off while arst_n is low
`timescale 1ns/1ps

module spi_flash_sva import spi_flash_pkg::*; (
    input logic       CSNeg_ipd,
    input logic       arst_n,
    input logic       cs_n,
    input logic       so,
    input flash_req_t req,
    input flash_rsp_t rsp
);

    // Output quiet while deselected and on the first selected cycle
    so_low_deselected: assert property (@(posedge CSNeg_ipd) disable iff (!arst_n)
        (cs_n || $past(cs_n)) |-> !so)
        else $error("so is high while cs_n is high or one cycle after it fell");

    // Busy only starts from an accepted program or erase
    busy_needs_request: assert property (@(posedge CSNeg_ipd) disable iff (!arst_n)
        $rose(rsp.busy) |-> (($past(req.op) == OP_PROGRAM) || ($past(req.op) == OP_ERASE)))
        else $error("busy rose without a program or erase request");

endmodule

/* verification/spi_flash_tb.sv */
// SPI mode 0 host with 4 clocks per sck half period; expected data comes from a byte model
`timescale 1ns/1ps
`include "spi_flash_cfg.svh"

module spi_flash_tb import spi_flash_pkg::*; ();

    localparam int HALF      = 4;      // Clocks per sck half period
    localparam int GAP       = 8;      // Idle clocks after deselect
    localparam int FRAME_MAX = 1040;
    localparam int MAX_POLLS = 20;
    localparam int MEM_BYTES = `FLASH_SECTORS * `FLASH_SECTOR_BYTES;

    logic   CSNeg_ipd;
    logic   arst_n;
    logic   sck;
    logic   cs_n;
    logic   si;
    logic   so;
    integer seed;
    int     errors;
    int     timeouts;
    byte_t  tx_buf [FRAME_MAX];
    byte_t  rx_buf [FRAME_MAX];
    byte_t  model  [MEM_BYTES];   // Expected array contents

    spi_flash_top i_spi_flash_top (
        .CSNeg_ipd (CSNeg_ipd),
        .arst_n    (arst_n),
        .sck       (sck),
        .cs_n      (cs_n),
        .si        (si),
        .so        (so)
    );

    bind spi_flash_top spi_flash_sva i_spi_flash_sva (
        .CSNeg_ipd (CSNeg_ipd),
        .arst_n    (arst_n),
        .cs_n      (cs_n),
        .so        (so),
        .req       (req),
        .rsp       (rsp)
    );

    always #50 CSNeg_ipd = ~CSNeg_ipd;

    ////////////////////////////////////////////////////////////
    // SPI host
    ////////////////////////////////////////////////////////////
    task automatic spi_byte(input byte_t tx, output byte_t rx);
        for (int i = 7; i >= 0; i--)
        begin
            @(posedge CSNeg_ipd);
            sck <= 1'b0;
            si  <= tx[i];
            repeat (HALF - 1) @(posedge CSNeg_ipd);
            @(posedge CSNeg_ipd);
            sck   <= 1'b1;
            rx[i] = so;   // Settled since the previous fall
            repeat (HALF - 1) @(posedge CSNeg_ipd);
        end
    endtask

    task automatic spi_frame(input int n);
        byte_t rx;
        @(posedge CSNeg_ipd);
        cs_n <= 1'b0;
        repeat (HALF) @(posedge CSNeg_ipd);
        for (int b = 0; b < n; b++)
        begin
            spi_byte(tx_buf[b], rx);
            rx_buf[b] = rx;
        end
        @(posedge CSNeg_ipd);
        sck <= 1'b0;
        si  <= 1'b0;
        repeat (HALF) @(posedge CSNeg_ipd);
        cs_n <= 1'b1;
        repeat (GAP) @(posedge CSNeg_ipd);
    endtask

    task automatic send_opcode(input byte_t op);
        tx_buf[0] = op;
        spi_frame(1);
    endtask

    task automatic load_addr(input byte_t op, input int addr);
        tx_buf[0] = op;
        tx_buf[1] = 8'h00;
        tx_buf[2] = byte_t'(addr >> 8);
        tx_buf[3] = byte_t'(addr);
    endtask

    task automatic read_status(output byte_t st);
        tx_buf[0] = 8'h05;
        tx_buf[1] = 8'h00;
        spi_frame(2);
        st = rx_buf[1];
    endtask

    function automatic byte_t status_word(input bit wip, input bit wel, input int bp);
        byte_t s;
        s = '0;
        s[`SR_WIP] = wip;
        s[`SR_WEL] = wel;
        s = s | byte_t'(bp << `SR_BP_LSB);
        return s;
    endfunction

    task automatic expect_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns: %s read %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic poll_wip();
        byte_t st;
        int    polls;
        polls = 0;
        read_status(st);
        while (st[`SR_WIP] && polls < MAX_POLLS)
        begin
            polls++;
            read_status(st);
        end
        if (st[`SR_WIP])
        begin
            timeouts++;
            $display("Timeout: WIP still set after %0d status polls at %0t ns", polls, $time);
        end
    endtask

    // READ n bytes from addr and compare with the model
    task automatic compare_readback(input int addr, input int n, input string what);
        int a;
        load_addr(8'h03, addr);
        for (int i = 0; i < n; i++)
            tx_buf[4 + i] = 8'h00;
        spi_frame(4 + n);
        for (int i = 0; i < n; i++)
        begin
            a = (addr + i) % MEM_BYTES;
            expect_byte(rx_buf[4 + i], model[a], $sformatf("%s at %03h", what, a));
        end
    endtask

    task automatic page_program(input int addr, input int n, input bit apply);
        byte_t       pb [`FLASH_PAGE_BYTES];
        logic        pv [`FLASH_PAGE_BYTES];
        logic [31:0] rnd;
        int          base;
        int          off;
        base = addr & ~(`FLASH_PAGE_BYTES - 1);
        for (int j = 0; j < `FLASH_PAGE_BYTES; j++)
            pv[j] = 1'b0;
        load_addr(8'h02, addr);
        for (int j = 0; j < n; j++)
        begin
            rnd = $random(seed);
            tx_buf[4 + j] = rnd[7:0];
            off = (addr + j) % `FLASH_PAGE_BYTES;   // Later bytes overwrite
            pb[off] = rnd[7:0];
            pv[off] = 1'b1;
        end
        spi_frame(4 + n);
        if (apply)
        begin
            for (int j = 0; j < `FLASH_PAGE_BYTES; j++)
            begin
                if (pv[j])
                    model[base + j] = model[base + j] & pb[j];
            end
        end
    endtask

    task automatic sector_erase(input int addr, input bit apply);
        int base;
        base = addr & ~(`FLASH_SECTOR_BYTES - 1);
        load_addr(8'hD8, addr);
        spi_frame(4);
        if (apply)
        begin
            for (int i = 0; i < `FLASH_SECTOR_BYTES; i++)
                model[base + i] = 8'hFF;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic status_bit_sequence();
        byte_t st;
        tx_buf[0] = 8'h05;
        tx_buf[1] = 8'h00;
        tx_buf[2] = 8'h00;
        spi_frame(3);
        expect_byte(rx_buf[1], 8'h00, "status after reset");
        expect_byte(rx_buf[2], 8'h00, "repeated status after reset");
        send_opcode(8'h06);
        read_status(st);
        expect_byte(st, status_word(0, 1, 0), "status after WREN");
        send_opcode(8'h04);
        read_status(st);
        expect_byte(st, status_word(0, 0, 0), "status after WRDI");
    endtask

    task automatic read_across_top();
        compare_readback(12'hFFE, 4, "READ across top");
    endtask

    task automatic program_and_wrap();
        byte_t st;
        send_opcode(8'h06);
        page_program(12'h120, `FLASH_PAGE_BYTES, 1'b1);
        poll_wip();
        read_status(st);
        expect_byte(st, 8'h00, "status after PP");
        compare_readback(12'h120, `FLASH_PAGE_BYTES, "page after PP");
        send_opcode(8'h06);
        page_program(12'h120, `FLASH_PAGE_BYTES + 2, 1'b1);   // Wraps onto offsets 0 and 1
        poll_wip();
        compare_readback(12'h120, `FLASH_PAGE_BYTES, "page after wrapped PP");
    endtask

    task automatic program_without_wren();
        byte_t st;
        page_program(12'h200, 8, 1'b0);
        read_status(st);
        expect_byte(st, 8'h00, "status after PP without WREN");
        compare_readback(12'h200, 8, "page after PP without WREN");
    endtask

    task automatic protected_sector_writes();
        byte_t st;
        send_opcode(8'h06);
        tx_buf[0] = 8'h01;
        tx_buf[1] = status_word(0, 0, 1);   // BP = 1, top sector
        spi_frame(2);
        read_status(st);
        expect_byte(st, status_word(0, 0, 1), "status after WRSR");
        send_opcode(8'h06);
        page_program(12'hC40, 8, 1'b0);
        read_status(st);
        expect_byte(st, status_word(0, 1, 1), "WEL after protected PP");
        sector_erase(12'hC00, 1'b0);
        read_status(st);
        expect_byte(st, status_word(0, 1, 1), "WEL after protected SE");
        compare_readback(12'hC40, 8, "protected sector");
    endtask

    // WEL is still set from the protected writes
    task automatic commands_while_busy();
        byte_t st;
        sector_erase(12'h000, 1'b1);
        read_status(st);
        expect_byte(st, status_word(1, 0, 1), "status during erase");
        load_addr(8'h03, 12'h800);
        tx_buf[4] = 8'h00;
        spi_frame(5);
        for (int i = 0; i < 5; i++)
            expect_byte(rx_buf[i], 8'h00, "so during READ while busy");
        poll_wip();
        read_status(st);
        expect_byte(st, status_word(0, 0, 1), "status after erase");
        compare_readback(12'h000, `FLASH_SECTOR_BYTES, "sector 0 after SE");
    endtask

    initial
    begin
        CSNeg_ipd = 1'b0;
        arst_n    = 1'b0;
        sck       = 1'b0;
        cs_n      = 1'b1;
        si        = 1'b0;
        seed      = 32'hd80dcbf6;
        errors    = 0;
        timeouts  = 0;
        for (int i = 0; i < MEM_BYTES; i++)
            model[i] = 8'hFF;
        repeat (4) @(posedge CSNeg_ipd);
        arst_n <= 1'b1;
        repeat (4) @(posedge CSNeg_ipd);

        status_bit_sequence();
        read_across_top();
        program_and_wrap();
        program_without_wren();
        protected_sector_writes();
        commands_while_busy();

        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* build.f */
+incdir+src
src/spi_flash_pkg.sv
src/spi_frontend.sv
src/cmd_sequencer.sv
src/flash_array.sv
src/spi_flash_top.sv
verification/spi_flash_sva.sv
verification/spi_flash_tb.sv

/* Bender.yml */
package:
  name: spi_flash

sources:
  - include_dirs:
      - src
    files:
      - src/spi_flash_pkg.sv
      - src/spi_frontend.sv
      - src/cmd_sequencer.sv
      - src/flash_array.sv
      - src/spi_flash_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/spi_flash_sva.sv
      - verification/spi_flash_tb.sv
